//--- cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

    // Geometry
    localparam int num_ways       = 4;
    localparam int num_sets       = 64;
    localparam int line_bits      = 128;
    localparam int word_bits      = 32;
    localparam int addr_bits      = 32;   // CPU byte address width

    localparam int words_per_line = line_bits / word_bits;

    // Address split widths
    localparam int offset_bits    = $clog2(line_bits / 8);  // Byte offset in a line
    localparam int word_sel_bits  = $clog2(words_per_line);
    localparam int index_bits     = $clog2(num_sets);
    localparam int tag_bits       = addr_bits - index_bits - offset_bits;
    localparam int way_bits       = $clog2(num_ways);

    // Register block
    localparam int csr_addr_bits  = 2;
    localparam int cnt_bits       = 16;   // Hit and miss counter width

endpackage

`default_nettype wire

//--- cache_types_pkg.sv
`default_nettype none

package cache_types_pkg;

    import cache_cfg_pkg::*;

    typedef logic [way_bits-1:0]   way_idx_t;
    typedef logic [index_bits-1:0] set_idx_t;
    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [word_bits-1:0]  word_t;

    // Word k sits at bits [32k+31:32k]
    typedef logic [line_bits-1:0]  line_t;

    // Tag array payload
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_fetch,       // Line read from memory
        st_fill,
        st_write_mem,   // Write-through of one word
        st_respond,
        st_flush
    } ctrl_state_t;

    // Register map
    typedef enum logic [csr_addr_bits-1:0] {
        csr_ctrl   = 2'd0,  // Bit 0 enable, bit 1 flush
        csr_hits   = 2'd1,
        csr_misses = 2'd2
    } csr_reg_e;

endpackage

`default_nettype wire

//--- way_array.sv
`timescale 1ns/1ps
`default_nettype none

module way_array import cache_cfg_pkg::*, cache_types_pkg::*; #(
    parameter type    entry_t   = line_t,
    parameter entry_t reset_val = '0
) (
    input  wire logic     clk_i,
    input  wire logic     rst_n,
    input  wire set_idx_t set_idx,
    output entry_t        rd_set [num_ways],
    input  wire logic     we,
    input  wire way_idx_t we_way,
    input  wire entry_t   wdata,
    input  wire logic     clear
);

    entry_t mem_q [num_sets][num_ways];

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    mem_q[s][w] <= reset_val;
                end
            end
        end else if (clear) begin
            // Whole array in one cycle
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    mem_q[s][w] <= reset_val;
                end
            end
        end else if (we) begin
            mem_q[set_idx][we_way] <= wdata;
        end
    end

    // Registered read of all ways in the set
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < num_ways; w++) begin
            rd_set[w] <= mem_q[set_idx][w];
        end
    end

endmodule

`default_nettype wire

//--- lru_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module lru_tracker import cache_cfg_pkg::*, cache_types_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n,
    input  wire set_idx_t set_idx,
    input  wire logic     touch,
    input  wire way_idx_t touch_way,
    output way_idx_t      victim_way
);

    // Slot 0 is most recent, last slot least recent
    way_idx_t order_q [num_sets][num_ways];
    way_idx_t cur_order [num_ways];
    way_idx_t new_order [num_ways];
    logic     found;

    always_comb begin
        for (int i = 0; i < num_ways; i++) begin
            cur_order[i] = order_q[set_idx][i];
        end
    end

    // Touched way goes to the front, ways ahead of it slide back one slot
    always_comb begin
        found        = 1'b0;
        new_order[0] = touch_way;
        for (int i = 1; i < num_ways; i++) begin
            if (cur_order[i-1] == touch_way) begin
                found = 1'b1;
            end
            new_order[i] = found ? cur_order[i] : cur_order[i-1];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int i = 0; i < num_ways; i++) begin
                    order_q[s][i] <= way_idx_t'(i);  // Way 0 most recent
                end
            end
        end else if (touch) begin
            for (int i = 0; i < num_ways; i++) begin
                order_q[set_idx][i] <= new_order[i];
            end
        end
    end

    assign victim_way = cur_order[num_ways-1];

endmodule

`default_nettype wire

//--- cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_cfg_pkg::*, cache_types_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n,

    // CPU side
    input  wire logic                 req_valid,
    input  wire logic                 req_write,
    input  wire logic [addr_bits-1:0] req_addr,
    input  wire word_t                req_wdata,
    output logic                      resp_ready,
    output word_t                     resp_rdata,

    // Memory side
    output logic                      mem_read,
    output logic                      mem_write,
    output logic [addr_bits-1:0]      mem_addr,
    output word_t                     mem_wdata,
    input  wire logic                 mem_done,
    input  wire line_t                mem_rdata,

    // Arrays
    output set_idx_t                  set_idx,
    input  wire tag_entry_t           tag_rd [num_ways],
    input  wire line_t                data_rd [num_ways],
    output logic                      tag_we,
    output logic                      data_we,
    output way_idx_t                  wr_way,
    output tag_entry_t                tag_wdata,
    output line_t                     data_wdata,
    output logic                      array_clear,

    // LRU
    output logic                      lru_touch,
    output way_idx_t                  lru_way,
    input  wire way_idx_t             victim_way,

    // CSR block
    input  wire logic                 cache_on,
    input  wire logic                 flush_req,
    output logic                      flush_ack,
    output logic                      hit_pulse,
    output logic                      miss_pulse
);

    localparam int byte_sel_bits = offset_bits - word_sel_bits;

    ctrl_state_t state_q, state_d;

    tag_t                     req_tag;
    logic [word_sel_bits-1:0] word_sel;
    logic                     hit;
    way_idx_t                 hit_way;
    way_idx_t                 way_q;    // Way chosen in compare
    logic                     fill_q;   // Read miss while enabled
    logic                     cmd_q;    // Memory command outstanding
    line_t                    line_q;
    word_t                    rdata_q;
    logic                     mem_ack;

    function automatic word_t get_word(input line_t line, input logic [word_sel_bits-1:0] sel);
        return line[sel*word_bits +: word_bits];
    endfunction

    function automatic line_t put_word(input line_t line, input logic [word_sel_bits-1:0] sel,
                                       input word_t word);
        line_t merged;
        merged = line;
        merged[sel*word_bits +: word_bits] = word;
        return merged;
    endfunction

    assign req_tag  = req_addr[addr_bits-1 -: tag_bits];
    assign set_idx  = req_addr[offset_bits +: index_bits];   // Request held, so set is stable
    assign word_sel = req_addr[byte_sel_bits +: word_sel_bits];

    // Parallel tag compare over the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (tag_rd[w].valid && tag_rd[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign mem_ack = cmd_q && mem_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (flush_req) begin
                    state_d = st_flush;  // Flush goes ahead of a waiting request
                end else if (req_valid) begin
                    state_d = st_compare;
                end
            end
            st_compare: begin
                if (req_write) begin
                    state_d = st_write_mem;
                end else if (cache_on && hit) begin
                    state_d = st_respond;
                end else begin
                    state_d = st_fetch;
                end
            end
            st_fetch:     if (mem_ack) state_d = fill_q ? st_fill : st_respond;
            st_fill:      state_d = st_respond;
            st_write_mem: if (mem_ack) state_d = st_respond;
            st_respond:   state_d = st_idle;
            st_flush:     state_d = st_idle;
            default:      state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            fill_q  <= 1'b0;
            cmd_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == st_compare) begin
                fill_q <= cache_on && !hit && !req_write;
            end
            if (mem_read || mem_write) begin
                cmd_q <= 1'b1;
            end else if (mem_done) begin
                cmd_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == st_compare) begin
            way_q   <= hit ? hit_way : victim_way;
            rdata_q <= req_write ? req_wdata : get_word(data_rd[hit_way], word_sel);
        end
        if (state_q == st_fetch && mem_ack) begin
            line_q  <= mem_rdata;
            rdata_q <= get_word(mem_rdata, word_sel);
        end
    end

    // Memory commands are single pulses on state entry
    assign mem_read  = (state_q == st_fetch) && !cmd_q;
    assign mem_write = (state_q == st_write_mem) && !cmd_q;
    assign mem_addr  = (state_q == st_fetch) ?
                       {req_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}} :
                       {req_addr[addr_bits-1:byte_sel_bits], {byte_sel_bits{1'b0}}};
    assign mem_wdata = req_wdata;

    // Write hit merges in compare, a fill installs in fill
    assign tag_we     = (state_q == st_fill);
    assign data_we    = tag_we || (state_q == st_compare && cache_on && hit && req_write);
    assign wr_way     = tag_we ? way_q : hit_way;
    assign tag_wdata  = '{valid: 1'b1, tag: req_tag};
    assign data_wdata = tag_we ? line_q : put_word(data_rd[hit_way], word_sel, req_wdata);

    assign lru_touch   = tag_we || (state_q == st_compare && cache_on && hit);
    assign lru_way     = wr_way;

    assign array_clear = (state_q == st_flush);
    assign flush_ack   = array_clear;

    assign hit_pulse  = (state_q == st_compare) && cache_on && hit;
    assign miss_pulse = (state_q == st_compare) && cache_on && !hit;

    assign resp_ready = (state_q == st_respond);
    assign resp_rdata = rdata_q;

endmodule

`default_nettype wire

//--- cache_csr.sv
`timescale 1ns/1ps
`default_nettype none

module cache_csr import cache_cfg_pkg::*, cache_types_pkg::*; (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n,
    input  wire logic                     csr_we,
    input  wire logic [csr_addr_bits-1:0] csr_addr,
    input  wire word_t                    csr_wdata,
    output word_t                         csr_rdata,
    output logic                          cache_on,
    output logic                          flush_req,
    input  wire logic                     flush_ack,
    input  wire logic                     hit_pulse,
    input  wire logic                     miss_pulse
);

    logic                enable_q;
    logic                flush_q;
    logic [cnt_bits-1:0] hits_q;
    logic [cnt_bits-1:0] misses_q;
    csr_reg_e            reg_sel;

    assign reg_sel = csr_reg_e'(csr_addr);

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= 1'b1;  // Cache comes up enabled
            flush_q  <= 1'b0;
        end else begin
            if (flush_ack) begin
                flush_q <= 1'b0;
            end
            if (csr_we && reg_sel == csr_ctrl) begin
                enable_q <= csr_wdata[0];
                if (csr_wdata[1]) begin
                    flush_q <= 1'b1;
                end
            end
        end
    end

    // Saturating counters, a write clears
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            hits_q   <= '0;
            misses_q <= '0;
        end else begin
            if (csr_we && reg_sel == csr_hits) begin
                hits_q <= '0;
            end else if (hit_pulse && hits_q != '1) begin
                hits_q <= hits_q + 1'b1;
            end
            if (csr_we && reg_sel == csr_misses) begin
                misses_q <= '0;
            end else if (miss_pulse && misses_q != '1) begin
                misses_q <= misses_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (reg_sel)
            csr_ctrl:   csr_rdata = {{(word_bits-2){1'b0}}, flush_q, enable_q};
            csr_hits:   csr_rdata = word_t'(hits_q);
            csr_misses: csr_rdata = word_t'(misses_q);
            default:    csr_rdata = '0;
        endcase
    end

    assign cache_on  = enable_q;
    assign flush_req = flush_q;

endmodule

`default_nettype wire

//--- l1_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_dcache import cache_cfg_pkg::*, cache_types_pkg::*; (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n,

    // CPU
    input  wire logic                     req_valid,
    input  wire logic                     req_write,
    input  wire logic [addr_bits-1:0]     req_addr,
    input  wire word_t                    req_wdata,
    output logic                          resp_ready,
    output word_t                         resp_rdata,

    // Backing memory
    output logic                          mem_read,
    output logic                          mem_write,
    output logic [addr_bits-1:0]          mem_addr,
    output word_t                         mem_wdata,
    input  wire logic                     mem_done,
    input  wire line_t                    mem_rdata,

    // Registers
    input  wire logic                     csr_we,
    input  wire logic [csr_addr_bits-1:0] csr_addr,
    input  wire word_t                    csr_wdata,
    output word_t                         csr_rdata
);

    set_idx_t   set_idx;
    tag_entry_t tag_rd [num_ways];
    line_t      data_rd [num_ways];
    logic       tag_we;
    logic       data_we;
    way_idx_t   wr_way;
    tag_entry_t tag_wdata;
    line_t      data_wdata;
    logic       array_clear;

    logic       lru_touch;
    way_idx_t   lru_way;
    way_idx_t   victim_way;

    logic       cache_on;
    logic       flush_req;
    logic       flush_ack;
    logic       hit_pulse;
    logic       miss_pulse;

    cache_ctrl u_ctrl (
        .clk_i, .rst_n,
        .req_valid, .req_write, .req_addr, .req_wdata, .resp_ready, .resp_rdata,
        .mem_read, .mem_write, .mem_addr, .mem_wdata, .mem_done, .mem_rdata,
        .set_idx, .tag_rd, .data_rd, .tag_we, .data_we, .wr_way,
        .tag_wdata, .data_wdata, .array_clear,
        .lru_touch, .lru_way, .victim_way,
        .cache_on, .flush_req, .flush_ack, .hit_pulse, .miss_pulse
    );

    cache_csr u_csr (
        .clk_i, .rst_n,
        .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
        .cache_on, .flush_req, .flush_ack, .hit_pulse, .miss_pulse
    );

    // Valid bits clear to zero
    way_array #(.entry_t(tag_entry_t), .reset_val('0)) tag_arr (
        .clk_i, .rst_n,
        .set_idx,
        .rd_set (tag_rd),
        .we     (tag_we),
        .we_way (wr_way),
        .wdata  (tag_wdata),
        .clear  (array_clear)
    );

    way_array #(.entry_t(line_t), .reset_val('0)) data_arr (
        .clk_i, .rst_n,
        .set_idx,
        .rd_set (data_rd),
        .we     (data_we),
        .we_way (wr_way),
        .wdata  (data_wdata),
        .clear  (array_clear)
    );

    lru_tracker u_lru (
        .clk_i, .rst_n,
        .set_idx,
        .touch     (lru_touch),
        .touch_way (lru_way),
        .victim_way
    );

endmodule

`default_nettype wire

//--- l1_dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module l1_dcache_checker import cache_cfg_pkg::*; (
    input wire logic                 clk_i,
    input wire logic                 rst_n,
    input wire logic                 resp_ready,
    input wire logic                 mem_read,
    input wire logic                 mem_write,
    input wire logic [addr_bits-1:0] mem_addr,
    input wire logic                 mem_done
);

    int   fail_cnt = 0;  // Failed assertions so far
    logic busy_q;        // Memory command waiting for mem_done

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (mem_read || mem_write) begin
            busy_q <= 1'b1;
        end else if (mem_done) begin
            busy_q <= 1'b0;
        end
    end

    resp_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n)
        resp_ready |=> !resp_ready)
    else begin
        fail_cnt++;
        $error("resp_ready held for more than one cycle");
    end

    cmd_excl_a: assert property (@(posedge clk_i) disable iff (!rst_n)
        !(mem_read && mem_write))
    else begin
        fail_cnt++;
        $error("mem_read and mem_write high together");
    end

    // One outstanding command at a time
    cmd_single_a: assert property (@(posedge clk_i) disable iff (!rst_n)
        (mem_read || mem_write) |-> !busy_q)
    else begin
        fail_cnt++;
        $error("memory command issued before mem_done");
    end

    line_addr_a: assert property (@(posedge clk_i) disable iff (!rst_n)
        mem_read |-> mem_addr[offset_bits-1:0] == '0)
    else begin
        fail_cnt++;
        $error("mem_read address not line aligned");
    end

endmodule

bind l1_dcache l1_dcache_checker u_chk (.*);

`default_nettype wire

//--- tb_l1_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1_dcache import cache_cfg_pkg::*, cache_types_pkg::*; ();

    logic                     clk_i;
    logic                     rst_n;
    logic                     req_valid;
    logic                     req_write;
    logic [addr_bits-1:0]     req_addr;
    word_t                    req_wdata;
    logic                     resp_ready;
    word_t                    resp_rdata;
    logic                     mem_read;
    logic                     mem_write;
    logic [addr_bits-1:0]     mem_addr;
    word_t                    mem_wdata;
    logic                     mem_done;
    line_t                    mem_rdata;
    logic                     csr_we;
    logic [csr_addr_bits-1:0] csr_addr;
    word_t                    csr_wdata;
    word_t                    csr_rdata;

    word_t    mem_model [16384];  // 64 KiB backing store, word addressed
    logic     ref_valid [num_sets][num_ways];
    tag_t     ref_tag   [num_sets][num_ways];
    line_t    ref_line  [num_sets][num_ways];
    way_idx_t ref_order [num_sets][num_ways];  // Slot 0 most recent
    logic     ref_on;
    int       ref_hits;
    int       ref_misses;
    word_t    exp_q [$];
    int       last_lat;
    int       errors;
    int       checks;

    l1_dcache dut_i (.*);

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return (tag << 10) | (set << 4) | (word << 2);
    endfunction

    // Expected result of one access, advances the model state
    function automatic logic model_access(input logic wr, input logic [31:0] addr,
                                          input word_t wdata, output word_t rdata);
        tag_t  tag;
        int    set;
        int    sel;
        int    way;
        int    pos;
        logic  hit;
        line_t line;
        tag = addr[31:10];
        set = addr[9:4];
        sel = addr[3:2];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_on && ref_valid[set][w] && ref_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (ref_on) begin
            if (hit) begin
                ref_hits++;
            end else begin
                ref_misses++;
            end
        end
        for (int k = 0; k < words_per_line; k++) begin
            line[k*32 +: 32] = mem_model[addr[15:4]*4 + k];
        end
        rdata = wr ? wdata : (hit ? ref_line[set][way][sel*32 +: 32] : line[sel*32 +: 32]);
        if (wr && hit) begin
            ref_line[set][way][sel*32 +: 32] = wdata;
        end
        if (ref_on && !wr && !hit) begin
            way = ref_order[set][num_ways-1];  // Least recent way is refilled
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way]   = tag;
            ref_line[set][way]  = line;
        end
        if (hit || (ref_on && !wr)) begin
            pos = 0;
            for (int i = 0; i < num_ways; i++) begin
                if (ref_order[set][i] == way) pos = i;
            end
            for (int i = pos; i > 0; i--) begin
                ref_order[set][i] = ref_order[set][i-1];
            end
            ref_order[set][0] = way_idx_t'(way);
        end
        return hit;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // One request, held until resp_ready
    task automatic access(input logic wr, input logic [31:0] addr, input word_t wdata);
        word_t exp;
        void'(model_access(wr, addr, wdata, exp));
        exp_q.push_back(exp);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        last_lat  = 0;
        do begin
            @(negedge clk_i);
            last_lat++;
        end while (!resp_ready);
        req_valid = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic csr_write(input logic [csr_addr_bits-1:0] addr, input word_t data);
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(negedge clk_i);
        csr_we    = 1'b0;
    endtask

    // csr_rdata follows csr_addr
    task automatic read_csr(input logic [csr_addr_bits-1:0] addr, output word_t data);
        csr_addr = addr;
        @(negedge clk_i);
        data = csr_rdata;
    endtask

    task automatic check_counters();
        word_t value;
        read_csr(csr_hits, value);
        check_value("hits", value, ref_hits);
        read_csr(csr_misses, value);
        check_value("misses", value, ref_misses);
    endtask

    // Compare process for read data
    always @(negedge clk_i) begin
        if (rst_n && resp_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("resp_ready pulsed while no request was outstanding");
            end else begin
                check_value("resp_rdata", resp_rdata, exp_q.pop_front());
            end
        end
    end

    // Backing memory, answers each command after 1 to 4 cycles
    initial begin : mem_resp
        int          delay;
        logic [31:0] addr;
        forever begin
            @(negedge clk_i);
            if (rst_n && (mem_read || mem_write)) begin
                addr = mem_addr;
                if (mem_write) mem_model[addr[15:2]] = mem_wdata;
                delay = 1 + $urandom % 4;
                repeat (delay) @(negedge clk_i);
                for (int k = 0; k < words_per_line; k++) begin
                    mem_rdata[k*32 +: 32] = mem_model[addr[15:4]*4 + k];
                end
                mem_done = 1'b1;
                @(negedge clk_i);
                mem_done = 1'b0;
            end
        end
    end

    // Directed plus random requests, 20 cycles each
    initial begin : watchdog
        repeat ((40 + 300) * 20) @(posedge clk_i);
        $display("Timeout, a request or memory handshake never completed");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        word_t       h0;
        word_t       m0;
        word_t       cnt;
        logic [31:0] addr;
        void'($urandom(32'h75dadd98));
        clk_i      = 1'b0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        mem_done   = 1'b0;
        mem_rdata  = '0;
        csr_we     = 1'b0;
        csr_addr   = '0;
        csr_wdata  = '0;
        errors     = 0;
        checks     = 0;
        ref_on     = 1'b1;
        ref_hits   = 0;
        ref_misses = 0;
        for (int i = 0; i < 16384; i++) begin
            mem_model[i] = (i * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
        end
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_order[s][w] = way_idx_t'(w);
            end
        end
        repeat (5) @(negedge clk_i);
        rst_n = 1'b1;
        @(negedge clk_i);

        // Miss then hit
        access(1'b0, make_addr(33, 1, 0), '0);
        access(1'b0, make_addr(33, 1, 0), '0);
        check_value("hit latency", last_lat, 2);
        check_counters();

        // Write-through on a hit, memory only on a miss
        addr = make_addr(33, 1, 1);
        access(1'b1, addr, 32'hcafe_0001);
        check_value("mem word", mem_model[addr[15:2]], 32'hcafe_0001);
        access(1'b0, addr, '0);
        addr = make_addr(34, 1, 2);
        access(1'b1, addr, 32'hbeef_0002);
        check_value("mem word", mem_model[addr[15:2]], 32'hbeef_0002);
        read_csr(csr_misses, m0);
        access(1'b0, addr, '0);
        read_csr(csr_misses, cnt);
        check_value("write miss refetch", cnt - m0, 1);
        check_counters();

        // Five tags in set 5
        read_csr(csr_hits, h0);
        read_csr(csr_misses, m0);
        for (int t = 40; t < 45; t++) access(1'b0, make_addr(t, 5, 0), '0);
        access(1'b0, make_addr(40, 5, 0), '0);  // Evicted by tag 44
        for (int t = 42; t < 45; t++) access(1'b0, make_addr(t, 5, 0), '0);
        read_csr(csr_misses, cnt);
        check_value("lru misses", cnt - m0, 6);
        read_csr(csr_hits, cnt);
        check_value("lru hits", cnt - h0, 3);
        check_counters();

        // Flush drops every line
        csr_write(csr_ctrl, 32'h3);
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
        read_csr(csr_misses, m0);
        access(1'b0, make_addr(33, 1, 1), '0);
        access(1'b0, make_addr(44, 5, 0), '0);
        read_csr(csr_misses, cnt);
        check_value("flush misses", cnt - m0, 2);
        check_counters();

        // Bypass while disabled
        access(1'b0, make_addr(50, 2, 3), '0);
        csr_write(csr_ctrl, 32'h0);
        ref_on = 1'b0;
        access(1'b0, make_addr(50, 2, 3), '0);
        addr = make_addr(51, 3, 0);
        access(1'b1, addr, 32'h1234_abcd);
        check_value("mem word", mem_model[addr[15:2]], 32'h1234_abcd);
        access(1'b0, addr, '0);
        check_counters();
        csr_write(csr_ctrl, 32'h1);
        ref_on = 1'b1;
        access(1'b0, make_addr(50, 2, 3), '0);  // Still cached
        access(1'b0, addr, '0);
        check_counters();

        // Random mix over 16 tags and 4 sets
        for (int n = 0; n < 300; n++) begin
            addr = make_addr($urandom % 16, 16 + $urandom % 4, $urandom % 4);
            if ($urandom % 3 == 0) begin
                access(1'b1, addr, $urandom);
            end else begin
                access(1'b0, addr, '0);
            end
        end
        check_counters();

        check_value("assertion failures", dut_i.u_chk.fail_cnt, 0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
cache_cfg_pkg.sv
cache_types_pkg.sv
way_array.sv
lru_tracker.sv
cache_ctrl.sv
cache_csr.sv
l1_dcache.sv
l1_dcache_checker.sv
tb_l1_dcache.sv

//--- Bender.yml
package:
  name: l1_dcache

sources:
  # Packages first, then the design from the leaves up
  - cache_cfg_pkg.sv
  - cache_types_pkg.sv
  - way_array.sv
  - lru_tracker.sv
  - cache_ctrl.sv
  - cache_csr.sv
  - l1_dcache.sv

  # Verification only
  - target: test
    files:
      - l1_dcache_checker.sv
      - tb_l1_dcache.sv
